//--- Makefile
# Verilator flow for the BCH decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_bch_decoder
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
VFLAGS    ?= --binary --assert -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# a crashed simulator also leaves the fail message in the log
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG): simulator exited with an error" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- chien/chien_search.sv
`timescale 1ns/10ps

module chien_search import bch_pkg::*; (
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_valid,
	input  gf_elem_t i_sigma0,
	input  gf_elem_t i_sigma1,
	input  gf_elem_t i_sigma2,
	input  cnt_t     i_degree,
	output logic     o_loc_valid,
	output loc_t     o_loc,
	output logic     o_done,
	output cnt_t     o_num_err,
	output logic     o_fail
);

	localparam gf_elem_t ALPHA_INV1 = gf_alpha_pow(CODE_N - 1);   // alpha^-1
	localparam gf_elem_t ALPHA_INV2 = gf_alpha_pow(CODE_N - 2);   // alpha^-2
	localparam loc_t     LAST_POS   = loc_t'(CODE_N - 1);

	logic     scanning;
	logic     last_q;       // position 62 reported this cycle
	loc_t     pos_q;
	gf_elem_t s0_q, t1_q, t2_q;
	cnt_t     degree_q;
	cnt_t     root_cnt;

	logic     active;
	logic     hit;
	loc_t     cur_pos;
	gf_elem_t cur_s0, cur_t1, cur_t2;
	cnt_t     cur_cnt;

	// position 0 is tested straight from the solver outputs
	assign active  = i_valid || scanning;
	assign cur_pos = i_valid ? loc_t'(0) : pos_q;
	assign cur_s0  = i_valid ? i_sigma0 : s0_q;
	assign cur_t1  = i_valid ? i_sigma1 : t1_q;
	assign cur_t2  = i_valid ? i_sigma2 : t2_q;
	assign cur_cnt = i_valid ? cnt_t'(0) : root_cnt;
	assign hit     = active && ((cur_s0 ^ cur_t1 ^ cur_t2) == '0);  // sigma(alpha^-pos) = 0

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			scanning    <= 1'b0;
			last_q      <= 1'b0;
			root_cnt    <= '0;
			o_loc_valid <= 1'b0;
			o_done      <= 1'b0;
			o_num_err   <= '0;
			o_fail      <= 1'b0;
		end else begin
			scanning    <= active && (cur_pos != LAST_POS);
			last_q      <= active && (cur_pos == LAST_POS);
			o_loc_valid <= hit;
			o_done      <= last_q;   // one cycle after the last location
			if (active)
				root_cnt <= cur_cnt + cnt_t'(hit);
			if (last_q) begin
				o_num_err <= root_cnt;
				o_fail    <= (root_cnt != degree_q);   // roots vs locator degree
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			s0_q     <= i_sigma0;
			degree_q <= i_degree;
		end
		if (active) begin
			t1_q  <= gf_mul(cur_t1, ALPHA_INV1);
			t2_q  <= gf_mul(cur_t2, ALPHA_INV2);
			pos_q <= cur_pos + 1'b1;
		end
		o_loc <= cur_pos;
	end

	// at most t locations per scan
	a_max_roots: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(hit && !i_valid) |-> (root_cnt < CODE_T));

endmodule

//--- common/bch_pkg.sv
package bch_pkg;

	//==================================================
	// field and code constants
	//==================================================
	localparam int GF_M       = 6;    // GF(2^6)
	localparam int CODE_N     = 63;   // positions 0..62
	localparam int CODE_T     = 2;    // double error correcting
	localparam int FRAME_BITS = 64;   // bit 63 is padding

	localparam logic [GF_M:0] PRIM_POLY = 7'b100_0011; // x^6 + x + 1

	typedef logic [GF_M-1:0] gf_elem_t;
	typedef logic [5:0]      loc_t;   // error position
	typedef logic [1:0]      cnt_t;   // error count or locator degree

	// shift-and-add product, reduced on every shift
	function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh  = a;
		for (int i = 0; i < GF_M; i++) begin
			if (b[i])
				acc = acc ^ sh;
			sh = {sh[GF_M-2:0], 1'b0} ^ (sh[GF_M-1] ? PRIM_POLY[GF_M-1:0] : gf_elem_t'(0));
		end
		return acc;
	endfunction

	// alpha^e by square and multiply, exponent taken mod n
	function automatic gf_elem_t gf_alpha_pow(int unsigned e);
		gf_elem_t    res;
		gf_elem_t    base;
		int unsigned r;
		r    = e % CODE_N;
		res  = gf_elem_t'(1);
		base = gf_elem_t'(2);   // alpha
		for (int i = 0; i < GF_M; i++) begin
			if (r[i])
				res = gf_mul(res, base);
			base = gf_mul(base, base);
		end
		return res;
	endfunction

endpackage

//--- ibm/ibm_solver.sv
`timescale 1ns/10ps

module ibm_solver import bch_pkg::*; (
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_valid,
	input  gf_elem_t i_s1,
	input  gf_elem_t i_s2,
	input  gf_elem_t i_s3,
	input  gf_elem_t i_s4,
	output gf_elem_t o_sigma0,
	output gf_elem_t o_sigma1,
	output gf_elem_t o_sigma2,
	output cnt_t     o_degree,
	output logic     o_valid
);

	typedef struct packed {
		gf_elem_t [2:0] sig;     // locator, truncated to t+1 terms
		gf_elem_t [2:0] b;       // correction polynomial
		gf_elem_t       gamma;   // previous discrepancy
		cnt_t           len;     // locator length
	} bm_state_t;

	localparam bm_state_t BM_INIT = '{
		sig:   {gf_elem_t'(0), gf_elem_t'(0), gf_elem_t'(1)},
		b:     {gf_elem_t'(0), gf_elem_t'(0), gf_elem_t'(1)},
		gamma: gf_elem_t'(1),
		len:   cnt_t'(0)
	};

	// one binary iteration, step 2r, sigma' = gamma*sigma + delta*x*b
	function automatic bm_state_t bm_step(bm_state_t st, gf_elem_t delta, int r);
		bm_state_t nx;
		nx.sig[0] = gf_mul(st.gamma, st.sig[0]);
		for (int i = 1; i < 3; i++)
			nx.sig[i] = gf_mul(st.gamma, st.sig[i]) ^ gf_mul(delta, st.b[i-1]);
		if (delta != '0 && 2 * int'(st.len) <= 2 * r) begin
			nx.b     = {st.sig[1], st.sig[0], gf_elem_t'(0)};   // x * sigma
			nx.len   = cnt_t'(2 * r + 1 - int'(st.len));
			nx.gamma = delta;
		end else begin
			nx.b     = {st.b[0], gf_elem_t'(0), gf_elem_t'(0)};  // x^2 * b
			nx.len   = st.len;
			nx.gamma = st.gamma;
		end
		return nx;
	endfunction

	bm_state_t st1_d, st1_q, st2_d;
	gf_elem_t  s1_q, s2_q, s3_q;
	gf_elem_t  delta1;
	logic      v1, v2;

	assign st1_d  = bm_step(BM_INIT, i_s1, 0);   // first discrepancy is S1
	assign delta1 = gf_mul(st1_q.sig[0], s3_q) ^ gf_mul(st1_q.sig[1], s2_q)
		^ gf_mul(st1_q.sig[2], s1_q);
	assign st2_d  = bm_step(st1_q, delta1, 1);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			v1      <= 1'b0;
			v2      <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			v1      <= i_valid;
			v2      <= v1;
			o_valid <= v2;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			st1_q <= st1_d;
			s1_q  <= i_s1;
			s2_q  <= i_s2;
			s3_q  <= i_s3;
		end
		if (v2) begin
			o_sigma0 <= st2_d.sig[0];
			o_sigma1 <= st2_d.sig[1];
			o_sigma2 <= st2_d.sig[2];
			o_degree <= st2_d.len;
		end
	end

	// binary code, even syndromes are squares of lower ones
	a_even_syndromes: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_valid |-> (i_s2 == gf_mul(i_s1, i_s1)) && (i_s4 == gf_mul(i_s2, i_s2)));

endmodule

//--- rtl/bch_decoder.sv
`timescale 1ns/10ps

module bch_decoder import bch_pkg::*; #(
	parameter int DATA_W = 8
) (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_set,
	input  logic [DATA_W-1:0] i_data,
	output logic              o_ready,
	output logic              o_loc_valid,
	output loc_t              o_loc,
	output logic              o_done,
	output cnt_t              o_num_err,
	output logic              o_fail
);

	logic     syn_start;
	logic     syn_en;
	logic     syn_valid;
	gf_elem_t syn_s1, syn_s2, syn_s3, syn_s4;
	gf_elem_t sigma0, sigma1, sigma2;
	cnt_t     sigma_degree;
	logic     sigma_valid;

	//==================================================
	// control
	//==================================================
	decode_control #(.DATA_W(DATA_W)) u_decode_control (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_set       (i_set),
		.i_done      (o_done),      // frame finished
		.o_ready     (o_ready),
		.o_syn_start (syn_start),   // first beat
		.o_syn_en    (syn_en)       // every beat
	);

	//==================================================
	// syndrome
	//==================================================
	syndrome_calc #(.DATA_W(DATA_W)) u_syndrome_calc (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_start (syn_start),
		.i_en    (syn_en),
		.i_data  (i_data),      // DATA_W bits
		.o_s1    (syn_s1),      // 6 bits
		.o_s2    (syn_s2),
		.o_s3    (syn_s3),
		.o_s4    (syn_s4),
		.o_valid (syn_valid)
	);

	//==================================================
	// ibm
	//==================================================
	ibm_solver u_ibm_solver (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_valid  (syn_valid),
		.i_s1     (syn_s1),
		.i_s2     (syn_s2),
		.i_s3     (syn_s3),
		.i_s4     (syn_s4),
		.o_sigma0 (sigma0),       // 6 bits
		.o_sigma1 (sigma1),
		.o_sigma2 (sigma2),
		.o_degree (sigma_degree), // 2 bits
		.o_valid  (sigma_valid)
	);

	//==================================================
	// chien_search
	//==================================================
	chien_search u_chien_search (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_valid     (sigma_valid),   // starts the scan
		.i_sigma0    (sigma0),
		.i_sigma1    (sigma1),
		.i_sigma2    (sigma2),
		.i_degree    (sigma_degree),
		.o_loc_valid (o_loc_valid),
		.o_loc       (o_loc),         // 6 bits
		.o_done      (o_done),
		.o_num_err   (o_num_err),     // 2 bits
		.o_fail      (o_fail)
	);

endmodule

//--- rtl/decode_control.sv
`timescale 1ns/10ps

module decode_control import bch_pkg::*; #(
	parameter int DATA_W = 8
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_set,
	input  logic i_done,
	output logic o_ready,
	output logic o_syn_start,
	output logic o_syn_en
);

	localparam int BEATS = FRAME_BITS / DATA_W;
	localparam int CNT_W = $clog2(BEATS + 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RECV,
		S_BUSY
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] beat_cnt;   // beats taken so far
	logic             accept;

	assign accept      = i_set && (state == S_IDLE);  // first beat sampled here
	assign o_ready     = (state == S_IDLE);
	assign o_syn_start = accept;
	assign o_syn_en    = accept || (state == S_RECV);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state    <= S_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (i_set) begin
						beat_cnt <= CNT_W'(1);
						state    <= (BEATS == 1) ? S_BUSY : S_RECV;
					end
				end
				S_RECV: begin
					beat_cnt <= beat_cnt + 1'b1;
					if (beat_cnt == CNT_W'(BEATS - 1))   // last beat in flight
						state <= S_BUSY;
				end
				S_BUSY: begin
					if (i_done)   // ready again next cycle
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// beats after the first one come only from receive, within the frame length
	a_syn_en_in_recv: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_syn_en && !o_syn_start) |-> (state == S_RECV) && (beat_cnt != '0)
			&& (beat_cnt < CNT_W'(BEATS)));

endmodule

//--- src.f
+incdir+testbench
common/bch_pkg.sv
rtl/decode_control.sv
syndrome/syndrome_calc.sv
ibm/ibm_solver.sv
chien/chien_search.sv
rtl/bch_decoder.sv
testbench/tb_bch_decoder.sv

//--- syndrome/syndrome_calc.sv
`timescale 1ns/10ps

module syndrome_calc import bch_pkg::*; #(
	parameter int DATA_W = 8
) (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_start,
	input  logic              i_en,
	input  logic [DATA_W-1:0] i_data,
	output gf_elem_t          o_s1,
	output gf_elem_t          o_s2,
	output gf_elem_t          o_s3,
	output gf_elem_t          o_s4,
	output logic              o_valid
);

	localparam int BEATS   = FRAME_BITS / DATA_W;
	localparam int CNT_W   = $clog2(BEATS + 1);
	localparam int NUM_SYN = 2 * CODE_T;

	logic [CNT_W-1:0] beat_cnt;
	logic [CNT_W-1:0] beat_idx;   // index of the beat on i_data
	gf_elem_t         syn_q [1:NUM_SYN];
	gf_elem_t         syn_d [1:NUM_SYN];

	assign beat_idx = i_start ? '0 : beat_cnt;

	// S_i += alpha^(i*pos) for each set bit
	always_comb begin
		int unsigned pos;
		for (int i = 1; i <= NUM_SYN; i++)
			syn_d[i] = i_start ? gf_elem_t'(0) : syn_q[i];
		for (int j = 0; j < DATA_W; j++) begin
			pos = int'(beat_idx) * DATA_W + j;
			if (i_data[j] && pos < CODE_N) begin   // pad bit masked
				for (int i = 1; i <= NUM_SYN; i++)
					syn_d[i] = syn_d[i] ^ gf_alpha_pow(i * pos);
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			beat_cnt <= '0;
			o_valid  <= 1'b0;
		end else begin
			o_valid <= i_en && (beat_idx == CNT_W'(BEATS - 1));
			if (i_en)
				beat_cnt <= beat_idx + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_en) begin
			for (int i = 1; i <= NUM_SYN; i++)
				syn_q[i] <= syn_d[i];
		end
	end

	assign o_s1 = syn_q[1];
	assign o_s2 = syn_q[2];
	assign o_s3 = syn_q[3];
	assign o_s4 = syn_q[4];

	a_start_with_en: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_start |-> i_en);

endmodule

//--- testbench/bch_tests.svh
function automatic int random_pos();
	return int'($unsigned($random(seed)) % CODE_N);   // 0..62
endfunction

task automatic report_mismatch(string sig, int got, int exp);
	$display("** Error at %0t ns: %s = %0d, expected %0d", $time, sig, got, exp);
	error_count++;
endtask

task automatic wait_ready();
	int waited;
	waited = 0;
	@(negedge i_clk);
	while (!o_ready && waited < DONE_LIMIT) begin
		@(negedge i_clk);
		waited++;
	end
	if (!o_ready) begin
		$display("o_ready stayed low for %0d cycles", DONE_LIMIT);
		error_count++;
	end
endtask

// beat k carries frame bits k*DATA_W and up
task automatic drive_frame(logic [FRAME_BITS-1:0] frame);
	@(posedge i_clk);
	i_set  <= 1'b1;
	i_data <= frame[DATA_W-1:0];
	for (int k = 1; k < BEATS; k++) begin
		@(posedge i_clk);
		i_set  <= 1'b0;
		i_data <= frame[k*DATA_W +: DATA_W];
	end
endtask

task automatic collect_result();
	int waited;
	waited = 0;
	got_locs.delete();
	do begin
		@(negedge i_clk);
		waited++;
		if (o_loc_valid)
			got_locs.push_back(int'(o_loc));
	end while (!o_done && waited < DONE_LIMIT);
	if (!o_done) begin
		$display("o_done did not arrive within %0d cycles", DONE_LIMIT);
		error_count++;
	end
	got_num_err = int'(o_num_err);
	got_fail    = o_fail;
endtask

// no o_done and no o_loc_valid for QUIET_CYCLES cycles
task automatic check_no_output(string reason);
	int stray;
	stray = 0;
	repeat (QUIET_CYCLES) begin
		@(negedge i_clk);
		if (o_done || o_loc_valid)
			stray++;
	end
	if (stray != 0) begin
		$display("%s", reason);
		error_count++;
	end
endtask

// every flipped real position in ascending order
function automatic void expect_from_frame(logic [FRAME_BITS-1:0] frame);
	exp_locs.delete();
	for (int p = 0; p < CODE_N; p++) begin
		if (frame[p])
			exp_locs.push_back(p);
	end
endfunction

task automatic check_result();
	if (got_locs.size() != exp_locs.size()) begin
		report_mismatch("o_loc_valid count", got_locs.size(), exp_locs.size());
	end else begin
		foreach (got_locs[i]) begin
			if (got_locs[i] != exp_locs[i])
				report_mismatch("o_loc", got_locs[i], exp_locs[i]);
		end
	end
	if (got_num_err != exp_locs.size())
		report_mismatch("o_num_err", got_num_err, exp_locs.size());
	if (got_fail !== 1'b0)
		report_mismatch("o_fail", int'(got_fail), 0);
endtask

task automatic decode_and_check(logic [FRAME_BITS-1:0] frame);
	wait_ready();
	drive_frame(frame);
	collect_result();
	expect_from_frame(frame);
	check_result();
endtask

//==================================================
// directed tests
//==================================================
task automatic test_no_errors();
	decode_and_check('0);   // all-zero codeword
endtask

task automatic test_single_error(int pos);
	logic [FRAME_BITS-1:0] frame;
	frame      = '0;
	frame[pos] = 1'b1;
	decode_and_check(frame);
endtask

task automatic test_two_errors();
	logic [FRAME_BITS-1:0] frame;
	int                    a;
	int                    b;
	a = random_pos();
	b = random_pos();
	while (b == a)
		b = random_pos();
	frame    = '0;
	frame[a] = 1'b1;
	frame[b] = 1'b1;
	decode_and_check(frame);
endtask

task automatic test_pad_bit();
	logic [FRAME_BITS-1:0] frame;
	frame                 = '0;
	frame[FRAME_BITS - 1] = 1'b1;   // pad only
	decode_and_check(frame);
	frame[random_pos()] = 1'b1;     // pad plus one error
	decode_and_check(frame);
endtask

task automatic test_start_handshake();
	logic [FRAME_BITS-1:0] frame;
	frame               = '0;
	frame[random_pos()] = 1'b1;
	wait_ready();
	drive_frame(frame);
	@(negedge i_clk);
	if (o_ready !== 1'b0)
		report_mismatch("o_ready", int'(o_ready), 0);
	@(posedge i_clk);
	i_set <= 1'b1;   // start request while busy
	@(posedge i_clk);
	i_set <= 1'b0;
	collect_result();
	expect_from_frame(frame);
	check_result();
	check_no_output("i_set while busy started a second frame");
	test_two_errors();   // next frame after o_ready returns
endtask

task automatic test_reset_mid_decode();
	logic [FRAME_BITS-1:0] frame;
	frame     = '0;
	frame[26] = 1'b1;    // due on the first reset edge
	frame[58] = 1'b1;    // still pending at the reset
	wait_ready();
	drive_frame(frame);
	repeat (30) @(posedge i_clk);
	i_rst_n <= 1'b0;
	@(posedge i_clk);
	@(negedge i_clk);
	if (o_loc_valid !== 1'b0)
		report_mismatch("o_loc_valid", int'(o_loc_valid), 0);
	if (o_ready !== 1'b1)
		report_mismatch("o_ready", int'(o_ready), 1);
	@(posedge i_clk);
	i_rst_n <= 1'b1;
	check_no_output("the frame cut by reset still produced output");
	test_two_errors();
endtask

//--- testbench/tb_bch_decoder.sv
`timescale 1ns/10ps

module tb_bch_decoder;
	import bch_pkg::*;

	localparam int DATA_W        = 8;
	localparam int BEATS         = FRAME_BITS / DATA_W;
	localparam int NUM_TESTS     = 8;
	localparam int TIMEOUT_LIMIT = NUM_TESTS * 80 * 2;   // cycles
	localparam int DONE_LIMIT    = 200;                  // per frame wait
	localparam int QUIET_CYCLES  = 80;

	logic              i_clk;
	logic              i_rst_n;
	logic              i_set;
	logic [DATA_W-1:0] i_data;
	logic              o_ready;
	logic              o_loc_valid;
	loc_t              o_loc;
	logic              o_done;
	cnt_t              o_num_err;
	logic              o_fail;

	int   error_count;
	int   cycle_count;
	int   seed;
	int   got_locs[$];   // positions seen on o_loc
	int   exp_locs[$];
	int   got_num_err;
	logic got_fail;

	bch_decoder #(.DATA_W(DATA_W)) dut_i (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_set       (i_set),
		.i_data      (i_data),
		.o_ready     (o_ready),
		.o_loc_valid (o_loc_valid),
		.o_loc       (o_loc),
		.o_done      (o_done),
		.o_num_err   (o_num_err),
		.o_fail      (o_fail)
	);

	//==================================================
	// clock and watchdog
	//==================================================
	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;   // 100 ns period
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_LIMIT) begin
			@(posedge i_clk);
			cycle_count++;
		end
		$display("Timeout: the run went past %0d cycles", TIMEOUT_LIMIT);
		$display("Errors found");
		$finish;
	end

	`include "bch_tests.svh"

	//==================================================
	// test sequence
	//==================================================
	initial begin
		error_count = 0;
		seed        = 32'hcc0e_1b04;
		i_rst_n     = 1'b0;
		i_set       = 1'b0;
		i_data      = '0;
		repeat (2) @(posedge i_clk);
		i_rst_n <= 1'b1;

		test_no_errors();
		test_single_error(0);
		test_single_error(CODE_N - 1);   // last real position
		test_single_error(random_pos());
		test_two_errors();
		test_pad_bit();
		test_start_handshake();
		test_reset_mid_decode();

		$display("Run complete, %0d error(s) counted", error_count);
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
